// ==== Makefile ====
# Verilator simulation of the integer pipeline

VERILATOR ?= verilator
TOP       ?= tb_int_pipe
FLIST     ?= int_pipe.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== alu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "int_pipe_params.svh"

module alu import int_pipe_pkg::*; (
  input  wire alu_op_t            alu_op,
  input  wire     [`IP_XLEN-1:0]  alu_src1,
  input  wire     [`IP_XLEN-1:0]  alu_src2,
  output logic    [`IP_XLEN-1:0]  alu_result
);

  localparam int MSB = `IP_XLEN - 1;
  localparam int SHW = $clog2(`IP_XLEN);

  logic                  use_sub;
  logic [`IP_XLEN-1:0]   adder_b;
  logic                  adder_cin;
  logic [`IP_XLEN-1:0]   adder_sum;
  logic                  adder_cout;
  logic [`IP_XLEN-1:0]   slt_res;
  logic [`IP_XLEN-1:0]   sltu_res;
  logic [`IP_XLEN-1:0]   sll_res;
  logic [2*`IP_XLEN-1:0] sr64_res;
  logic [`IP_XLEN-1:0]   sr_res;

  // one adder, src1 - src2 as src1 + ~src2 + 1
  assign use_sub   = alu_op.op_sub | alu_op.op_slt | alu_op.op_sltu;
  assign adder_b   = use_sub ? ~alu_src2 : alu_src2;
  assign adder_cin = use_sub;
  assign {adder_cout, adder_sum} = {1'b0, alu_src1} + {1'b0, adder_b}
                                 + {{`IP_XLEN{1'b0}}, adder_cin};

  // signs differ -> src1 sign decides, else the difference sign
  assign slt_res[MSB:1] = '0;
  assign slt_res[0]     = (alu_src1[MSB] & ~alu_src2[MSB])
                        | ((alu_src1[MSB] ~^ alu_src2[MSB]) & adder_sum[MSB]);

  assign sltu_res[MSB:1] = '0;
  assign sltu_res[0]     = ~adder_cout;  // borrow out

  assign sll_res = alu_src1 << alu_src2[SHW-1:0];

  // upper half filled with the sign only for sra
  assign sr64_res = {{`IP_XLEN{alu_op.op_sra & alu_src1[MSB]}}, alu_src1}
                    >> alu_src2[SHW-1:0];
  assign sr_res   = sr64_res[MSB:0];

  assign alu_result = ({`IP_XLEN{alu_op.op_add | alu_op.op_sub}} & adder_sum)
                    | ({`IP_XLEN{alu_op.op_slt}}                 & slt_res)
                    | ({`IP_XLEN{alu_op.op_sltu}}                & sltu_res)
                    | ({`IP_XLEN{alu_op.op_and}}                 & (alu_src1 & alu_src2))
                    | ({`IP_XLEN{alu_op.op_nor}}                 & ~(alu_src1 | alu_src2))
                    | ({`IP_XLEN{alu_op.op_or}}                  & (alu_src1 | alu_src2))
                    | ({`IP_XLEN{alu_op.op_xor}}                 & (alu_src1 ^ alu_src2))
                    | ({`IP_XLEN{alu_op.op_lui}}                 & alu_src2)
                    | ({`IP_XLEN{alu_op.op_sll}}                 & sll_res)
                    | ({`IP_XLEN{alu_op.op_srl | alu_op.op_sra}} & sr_res);

  // the AND-OR select is only meaningful with a single flag
  a_op_onehot: assert final ($onehot0(alu_op))
    else $error("alu: more than one operation selected");

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "int_pipe_params.svh"

module ex_stage import int_pipe_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,
  input  wire id_ex_t  id_ex,
  output fwd_t         ex_fwd,
  output ex_wb_t       ex_wb
);

  logic [`IP_XLEN-1:0] alu_res;

  alu i_alu (
    .alu_op     (id_ex.alu_op),
    .alu_src1   (id_ex.src1),
    .alu_src2   (id_ex.src2),
    .alu_result (alu_res)
  );

  // same-cycle tap, lets a dependent instruction follow with no bubble
  assign ex_fwd.valid = id_ex.valid;
  assign ex_fwd.dest  = id_ex.dest;
  assign ex_fwd.data  = alu_res;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_wb.valid <= 1'b0;
    end else begin
      ex_wb.valid <= id_ex.valid;
      ex_wb.dest  <= id_ex.dest;
      ex_wb.data  <= alu_res;
    end
  end

  // a retired result is fully known
  a_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
    ex_wb.valid |-> !$isunknown({ex_wb.dest, ex_wb.data}))
    else $error("ex_stage: valid ex_wb with unknown dest or data");

endmodule

`default_nettype wire

// ==== id_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "int_pipe_params.svh"

module id_stage import int_pipe_pkg::*; (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     instr_valid,
  input  wire      [31:0]         instr,
  output reg_idx_t                raddr1,
  output reg_idx_t                raddr2,
  input  wire      [`IP_XLEN-1:0] rdata1,
  input  wire      [`IP_XLEN-1:0] rdata2,
  input  wire fwd_t               ex_fwd,
  input  wire ex_wb_t             wb_fwd,
  output id_ex_t                  id_ex,
  output logic                    illegal
);

  logic [16:0]         op17;
  logic [9:0]          op10;
  logic [6:0]          op7;
  reg_idx_t            rd;
  reg_idx_t            rj;
  reg_idx_t            rk;
  logic [4:0]          ui5;
  logic [11:0]         si12;
  logic [19:0]         si20;
  alu_op_t             op;
  logic                is_shi;
  logic                is_addi;
  logic                legal;
  logic [`IP_XLEN-1:0] opnd1;
  logic [`IP_XLEN-1:0] opnd2;
  id_ex_t              id_ex_d;

  // execute result first, then writeback, then the register file
  function automatic logic [`IP_XLEN-1:0] pick_src(input reg_idx_t            idx,
                                                    input logic [`IP_XLEN-1:0] rf,
                                                    input fwd_t                ex,
                                                    input ex_wb_t              wb);
    if (idx != '0 && ex.valid && ex.dest == idx) return ex.data;
    if (idx != '0 && wb.valid && wb.dest == idx) return wb.data;
    return rf;
  endfunction

  assign op17 = instr[31:15];
  assign op10 = instr[31:22];
  assign op7  = instr[31:25];
  assign rd   = instr[RD_LSB +: REG_W];
  assign rj   = instr[RJ_LSB +: REG_W];
  assign rk   = instr[RK_LSB +: REG_W];
  assign ui5  = instr[UI5_LSB +: 5];
  assign si12 = instr[SI12_LSB +: 12];
  assign si20 = instr[SI20_LSB +: 20];

  assign raddr1 = rj;
  assign raddr2 = rk;

  always_comb begin
    op      = '0;
    is_shi  = 1'b0;
    is_addi = 1'b0;
    case (op17)
      `IP_OP_ADD_W:  op.op_add  = 1'b1;
      `IP_OP_SUB_W:  op.op_sub  = 1'b1;
      `IP_OP_SLT:    op.op_slt  = 1'b1;
      `IP_OP_SLTU:   op.op_sltu = 1'b1;
      `IP_OP_NOR:    op.op_nor  = 1'b1;
      `IP_OP_AND:    op.op_and  = 1'b1;
      `IP_OP_OR:     op.op_or   = 1'b1;
      `IP_OP_XOR:    op.op_xor  = 1'b1;
      `IP_OP_SLL_W:  op.op_sll  = 1'b1;
      `IP_OP_SRL_W:  op.op_srl  = 1'b1;
      `IP_OP_SRA_W:  op.op_sra  = 1'b1;
      `IP_OP_SLLI_W: begin op.op_sll = 1'b1; is_shi = 1'b1; end
      `IP_OP_SRLI_W: begin op.op_srl = 1'b1; is_shi = 1'b1; end
      `IP_OP_SRAI_W: begin op.op_sra = 1'b1; is_shi = 1'b1; end
      default: begin
        if (op10 == `IP_OP_ADDI_W) begin
          op.op_add = 1'b1;
          is_addi   = 1'b1;
        end else if (op7 == `IP_OP_LU12I_W) begin
          op.op_lui = 1'b1;
        end
      end
    endcase
  end

  assign legal = |op;
  assign opnd1 = pick_src(rj, rdata1, ex_fwd, wb_fwd);
  assign opnd2 = pick_src(rk, rdata2, ex_fwd, wb_fwd);

  always_comb begin
    id_ex_d.valid  = instr_valid & legal;
    id_ex_d.alu_op = op;
    id_ex_d.dest   = rd;
    id_ex_d.src1   = op.op_lui ? '0 : opnd1;
    if (op.op_lui)    id_ex_d.src2 = {si20, 12'b0};
    else if (is_shi)  id_ex_d.src2 = {{(`IP_XLEN-5){1'b0}}, ui5};
    else if (is_addi) id_ex_d.src2 = {{(`IP_XLEN-12){si12[11]}}, si12};
    else              id_ex_d.src2 = opnd2;  // 3R
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex   <= '0;
      illegal <= 1'b0;
    end else begin
      id_ex   <= id_ex_d;
      illegal <= instr_valid & ~legal;  // one pulse per bad word
    end
  end

  // operands come from forwarding or the register file, never unknown
  a_valid_has_op: assert property (@(posedge clk) disable iff (!rst_n)
    id_ex.valid |-> !$isunknown({id_ex.src1, id_ex.src2}))
    else $error("id_stage: valid id_ex with unknown operands");

endmodule

`default_nettype wire

// ==== int_pipe.f ====
+incdir+.
int_pipe_pkg.sv
regfile.sv
alu.sv
id_stage.sv
ex_stage.sv
int_pipe.sv
tb_int_pipe.sv

// ==== int_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "int_pipe_params.svh"

module int_pipe import int_pipe_pkg::*; (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  instr_valid,
  input  wire [31:0]           instr,
  output logic                 wb_valid,
  output reg_idx_t             wb_dest,
  output logic [`IP_XLEN-1:0]  wb_data,
  output logic                 illegal
);

  reg_idx_t            raddr1;
  reg_idx_t            raddr2;
  logic [`IP_XLEN-1:0] rdata1;
  logic [`IP_XLEN-1:0] rdata2;
  id_ex_t              id_ex;
  fwd_t                ex_fwd;
  ex_wb_t              ex_wb;

  id_stage i_id (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .raddr1      (raddr1),
    .raddr2      (raddr2),
    .rdata1      (rdata1),
    .rdata2      (rdata2),
    .ex_fwd      (ex_fwd),
    .wb_fwd      (ex_wb),   // second forwarding source
    .id_ex       (id_ex),
    .illegal     (illegal)
  );

  ex_stage i_ex (
    .clk    (clk),
    .rst_n  (rst_n),
    .id_ex  (id_ex),
    .ex_fwd (ex_fwd),
    .ex_wb  (ex_wb)
  );

  regfile i_rf (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wr     (ex_wb)
  );

  // retired results
  assign wb_valid = ex_wb.valid;
  assign wb_dest  = ex_wb.dest;
  assign wb_data  = ex_wb.data;

endmodule

`default_nettype wire

// ==== int_pipe_params.svh ====
`ifndef INT_PIPE_PARAMS_SVH
`define INT_PIPE_PARAMS_SVH

`define IP_XLEN  32  // datapath width
`define IP_NREGS 32  // architectural registers

// 3R opcodes, instr[31:15]
`define IP_OP_ADD_W   17'h00020
`define IP_OP_SUB_W   17'h00022
`define IP_OP_SLT     17'h00024
`define IP_OP_SLTU    17'h00025
`define IP_OP_NOR     17'h00028
`define IP_OP_AND     17'h00029
`define IP_OP_OR      17'h0002a
`define IP_OP_XOR     17'h0002b
`define IP_OP_SLL_W   17'h0002e
`define IP_OP_SRL_W   17'h0002f
`define IP_OP_SRA_W   17'h00030

// shift by ui5, also instr[31:15]
`define IP_OP_SLLI_W  17'h00081
`define IP_OP_SRLI_W  17'h00089
`define IP_OP_SRAI_W  17'h00091

`define IP_OP_ADDI_W  10'h00a  // instr[31:22]
`define IP_OP_LU12I_W 7'h0a    // instr[31:25]

`endif

// ==== int_pipe_pkg.sv ====
`default_nettype none

`include "int_pipe_params.svh"

package int_pipe_pkg;

  localparam int REG_W = $clog2(`IP_NREGS);

  // instruction field positions
  localparam int RD_LSB   = 0;
  localparam int RJ_LSB   = 5;
  localparam int RK_LSB   = 10;
  localparam int UI5_LSB  = 10;
  localparam int SI12_LSB = 10;
  localparam int SI20_LSB = 5;

  typedef logic [REG_W-1:0] reg_idx_t;

  // one-hot ALU control, op_add is bit 0 and op_lui bit 11
  typedef struct packed {
    logic op_lui;
    logic op_sra;
    logic op_srl;
    logic op_sll;
    logic op_xor;
    logic op_or;
    logic op_nor;
    logic op_and;
    logic op_sltu;
    logic op_slt;
    logic op_sub;
    logic op_add;
  } alu_op_t;

  typedef struct packed {
    logic                valid;
    alu_op_t             alu_op;
    logic [`IP_XLEN-1:0] src1;
    logic [`IP_XLEN-1:0] src2;
    reg_idx_t            dest;
  } id_ex_t;

  typedef struct packed {
    logic                valid;
    reg_idx_t            dest;
    logic [`IP_XLEN-1:0] data;
  } ex_wb_t;

  // same fields as ex_wb_t, driven straight from the ALU
  typedef struct packed {
    logic                valid;
    reg_idx_t            dest;
    logic [`IP_XLEN-1:0] data;
  } fwd_t;

endpackage

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "int_pipe_params.svh"

module regfile import int_pipe_pkg::*; (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire reg_idx_t             raddr1,
  input  wire reg_idx_t             raddr2,
  output logic     [`IP_XLEN-1:0]   rdata1,
  output logic     [`IP_XLEN-1:0]   rdata2,
  input  wire ex_wb_t               wr
);

  logic [`IP_XLEN-1:0] mem [`IP_NREGS];
  logic                wr_en;

  // r0 is never written
  assign wr_en = wr.valid && (wr.dest != '0);

  // every register reads zero out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `IP_NREGS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr.dest] <= wr.data;
    end
  end

  // async read ports
  assign rdata1 = (raddr1 == '0) ? '0 : mem[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : mem[raddr2];

endmodule

`default_nettype wire

// ==== tb_int_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "int_pipe_params.svh"

module tb_int_pipe import int_pipe_pkg::*; ();

  localparam int DRAIN_LIMIT = 50;

  localparam logic [16:0] OPS_3R [11] = '{`IP_OP_ADD_W, `IP_OP_SUB_W, `IP_OP_SLT, `IP_OP_SLTU,
    `IP_OP_NOR, `IP_OP_AND, `IP_OP_OR, `IP_OP_XOR, `IP_OP_SLL_W, `IP_OP_SRL_W, `IP_OP_SRA_W};
  localparam logic [16:0] OPS_SHI [3] = '{`IP_OP_SLLI_W, `IP_OP_SRLI_W, `IP_OP_SRAI_W};
  // loaded into r1..r6 before the 3R sweep
  localparam logic [31:0] CORNERS [6] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000,
                                          32'h7fff_ffff, 32'h0000_0001, 32'h0000_001f};

  typedef struct packed {
    logic                legal;
    reg_idx_t            dest;
    logic [`IP_XLEN-1:0] data;
  } ref_t;

  typedef struct packed {
    reg_idx_t            dest;
    logic [`IP_XLEN-1:0] data;
    logic [31:0]         stamp;  // edge that drove the instruction
  } exp_t;

  logic                clk;
  logic                rst_n;
  logic                instr_valid;
  logic [31:0]         instr;
  logic                wb_valid;
  reg_idx_t            wb_dest;
  logic [`IP_XLEN-1:0] wb_data;
  logic                illegal;

  logic [`IP_XLEN-1:0] model_rf [`IP_NREGS];
  exp_t                exp_q [$];
  logic [31:0]         ill_q [$];
  logic [31:0]         cyc;
  string               test_name;

  int_pipe i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_dest     (wb_dest),
    .wb_data     (wb_data),
    .illegal     (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) cyc <= '0;
    else        cyc <= cyc + 32'd1;  // edge count
  end

  // ISA semantics over the model register array
  function automatic ref_t ref_model(input logic [31:0] ins);
    ref_t        r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm12;
    a       = model_rf[ins[9:5]];
    b       = model_rf[ins[14:10]];
    imm12   = {{20{ins[21]}}, ins[21:10]};
    r.legal = 1'b1;
    r.dest  = ins[4:0];
    r.data  = '0;
    case (ins[31:15])
      `IP_OP_ADD_W:  r.data = a + b;
      `IP_OP_SUB_W:  r.data = a - b;
      `IP_OP_SLT:    r.data = {31'b0, $signed(a) < $signed(b)};
      `IP_OP_SLTU:   r.data = {31'b0, a < b};
      `IP_OP_NOR:    r.data = ~(a | b);
      `IP_OP_AND:    r.data = a & b;
      `IP_OP_OR:     r.data = a | b;
      `IP_OP_XOR:    r.data = a ^ b;
      `IP_OP_SLL_W:  r.data = a << b[4:0];
      `IP_OP_SRL_W:  r.data = a >> b[4:0];
      `IP_OP_SRA_W:  r.data = $signed(a) >>> b[4:0];
      `IP_OP_SLLI_W: r.data = a << ins[14:10];
      `IP_OP_SRLI_W: r.data = a >> ins[14:10];
      `IP_OP_SRAI_W: r.data = $signed(a) >>> ins[14:10];
      default: begin
        if (ins[31:22] == `IP_OP_ADDI_W)       r.data = a + imm12;
        else if (ins[31:25] == `IP_OP_LU12I_W) r.data = {ins[24:5], 12'b0};
        else                                   r.legal = 1'b0;
      end
    endcase
    return r;
  endfunction

  function automatic logic [31:0] enc_3r(input logic [16:0] op, input reg_idx_t rd,
                                         input reg_idx_t rj, input reg_idx_t rk);
    return {op, rk, rj, rd};
  endfunction

  function automatic logic [31:0] enc_shi(input logic [16:0] op, input reg_idx_t rd,
                                          input reg_idx_t rj, input logic [4:0] ui5);
    return {op, ui5, rj, rd};
  endfunction

  function automatic logic [31:0] enc_addi(input reg_idx_t rd, input reg_idx_t rj,
                                           input logic [11:0] si12);
    return {`IP_OP_ADDI_W, si12, rj, rd};
  endfunction

  function automatic logic [31:0] enc_lu12i(input reg_idx_t rd, input logic [19:0] si20);
    return {`IP_OP_LU12I_W, si20, rd};
  endfunction

  function automatic logic [31:0] rand_legal();
    reg_idx_t rd;
    reg_idx_t rj;
    int       sel;
    rd  = 5'($urandom_range(15));  // small set, many hazards
    rj  = 5'($urandom_range(15));
    sel = $urandom_range(15);
    if (sel < 11) return enc_3r(OPS_3R[sel], rd, rj, 5'($urandom_range(15)));
    if (sel < 14) return enc_shi(OPS_SHI[sel-11], rd, rj, 5'($urandom));
    if (sel == 14) return enc_addi(rd, rj, 12'($urandom));
    return enc_lu12i(rd, 20'($urandom));
  endfunction

  // top bits all ones, or the unused neighbour of add.w
  function automatic logic [31:0] bad_word();
    if ($urandom_range(1) == 0) return $urandom() | 32'hfc00_0000;
    return {17'h00021, 15'($urandom)};
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic mismatch(input string what, input logic [31:0] expv, input logic [31:0] actv);
    stop_run($sformatf("[FAIL] %s: %s expected %0h, got %0h", test_name, what, expv, actv));
  endtask

  task automatic issue(input logic [31:0] ins);
    ref_t r;
    exp_t e;
    r = ref_model(ins);
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= ins;
    if (r.legal) begin
      if (r.dest != '0) model_rf[r.dest] = r.data;  // r0 stays zero
      e.dest  = r.dest;
      e.data  = r.data;
      e.stamp = cyc + 32'd1;
      exp_q.push_back(e);
    end else begin
      ill_q.push_back(cyc + 32'd1);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      instr_valid <= 1'b0;
      instr       <= $urandom();  // ignored while not valid
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    idle(1);
    while ((exp_q.size() != 0 || ill_q.size() != 0) && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    assert (exp_q.size() == 0 && ill_q.size() == 0)
      else stop_run($sformatf("%s: pipeline did not drain within %0d cycles",
                              test_name, DRAIN_LIMIT));
  endtask

  task automatic load_reg(input reg_idx_t rd, input logic [31:0] v);
    issue(enc_lu12i(rd, 20'((v + 32'h800) >> 12)));
    issue(enc_addi(rd, rd, v[11:0]));  // back to back, distance 1
  endtask

  task automatic random_stream(input int n, input int ill_pct, input int gap_pct);
    for (int i = 0; i < n; i++) begin
      if ($urandom_range(99) < ill_pct) issue(bad_word());
      else                              issue(rand_legal());
      if ($urandom_range(99) < gap_pct) idle($urandom_range(3, 1));
    end
    drain();
  endtask

  always @(negedge clk) begin : check_outputs
    exp_t e;
    if (rst_n) begin
      if (wb_valid) begin
        assert (exp_q.size() != 0)
          else stop_run($sformatf("%s: writeback with no instruction outstanding", test_name));
        e = exp_q.pop_front();
        assert (wb_dest == e.dest) else mismatch("wb_dest", 32'(e.dest), 32'(wb_dest));
        assert (wb_data == e.data) else mismatch("wb_data", e.data, wb_data);
        assert (cyc == e.stamp + 32'd2) else mismatch("retire edge", e.stamp + 32'd2, cyc);
      end
      if (illegal) begin
        assert (ill_q.size() != 0)
          else stop_run($sformatf("%s: illegal pulse with no bad word sent", test_name));
        assert (cyc == ill_q[0] + 32'd1) else mismatch("illegal edge", ill_q[0] + 32'd1, cyc);
        void'(ill_q.pop_front());
      end
      // nothing may be overdue
      assert (exp_q.size() == 0 || exp_q[0].stamp + 32'd2 > cyc)
        else stop_run($sformatf("%s: writeback missing for dest r%0d", test_name, exp_q[0].dest));
      assert (ill_q.size() == 0 || ill_q[0] + 32'd1 > cyc)
        else stop_run($sformatf("%s: illegal pulse missing", test_name));
    end
  end

  initial begin
    void'($urandom(11903));
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    test_name   = "reset";
    for (int i = 0; i < `IP_NREGS; i++) model_rf[i] = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    test_name = "alu_3r_corners";
    for (int i = 0; i < 6; i++) load_reg(5'(i + 1), CORNERS[i]);
    for (int op = 0; op < 11; op++)
      for (int j = 0; j < 7; j++)
        for (int k = 0; k < 7; k++)
          issue(enc_3r(OPS_3R[op], 5'd10, 5'(j), 5'(k)));
    drain();

    test_name = "imm_forms";
    for (int r = 0; r < 7; r++) begin
      for (int s = 0; s < 3; s++) begin
        issue(enc_shi(OPS_SHI[s], 5'd11, 5'(r), 5'd0));
        issue(enc_shi(OPS_SHI[s], 5'd11, 5'(r), 5'd31));
        issue(enc_shi(OPS_SHI[s], 5'd11, 5'(r), 5'($urandom)));
      end
      issue(enc_addi(5'd11, 5'(r), 12'hfff));
      issue(enc_addi(5'd11, 5'(r), 12'h800));
      issue(enc_addi(5'd11, 5'(r), 12'h7ff));
    end
    issue(enc_lu12i(5'd11, 20'hfffff));
    issue(enc_lu12i(5'd11, 20'h80000));
    issue(enc_lu12i(5'd11, 20'($urandom)));
    drain();

    test_name = "fwd_chains";
    // d registers in rotation, each read d instructions after its write
    for (int d = 1; d <= 3; d++) begin
      for (int k = 0; k < 24; k++) begin
        case (k % 3)
          0: issue(enc_addi(5'(12 + k % d), 5'(12 + k % d), 12'(k * 37 + 1)));
          1: issue(enc_3r(`IP_OP_ADD_W, 5'(12 + k % d), 5'd5, 5'(12 + k % d)));
          default: issue(enc_3r(`IP_OP_XOR, 5'(12 + k % d), 5'(12 + k % d), 5'd3));
        endcase
      end
      drain();
    end

    test_name = "r0_writes";
    issue(enc_3r(`IP_OP_ADD_W, 5'd0, 5'd4, 5'd5));  // data 0x80000000 to r0
    issue(enc_3r(`IP_OP_OR, 5'd13, 5'd0, 5'd0));
    issue(enc_addi(5'd0, 5'd2, 12'h123));
    issue(enc_addi(5'd14, 5'd0, 12'h000));
    issue(enc_lu12i(5'd0, 20'habcde));
    idle(4);
    issue(enc_3r(`IP_OP_ADD_W, 5'd15, 5'd0, 5'd5));  // regfile path
    drain();

    test_name = "illegal_mix";
    random_stream(400, 20, 10);

    test_name = "random_latency";
    random_stream(2000, 5, 25);

    idle(8);  // any stray writeback shows up here
    if (exp_q.size() == 0 && ill_q.size() == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      stop_run("outputs still outstanding at the end of the run");
    end
  end

endmodule

`default_nettype wire
